// File: common/cnn_defines.svh
`ifndef CNN_DEFINES_SVH
`define CNN_DEFINES_SVH

// --------------------
// Datapath widths
// --------------------
`define CNN_PIX_W      8     // Pixel and weight bits
`define CNN_TAPS       9     // 3x3 window
`define CNN_N_KERN     4     // Output channels
`define CNN_PARAM_W    16    // Scale and bias bits

// --------------------
// Image geometry
// --------------------
`define CNN_MAX_DIM    16    // Largest width or height
`define CNN_DIM_W      5     // Row and column index bits
`define CNN_IMG_DEPTH  256   // Image buffer words
`define CNN_IMG_AW     8     // Image buffer address bits
`define CNN_DELAY_W    12    // Start-up and hsync counters

// --------------------
// AHB address fields
// --------------------
`define CNN_REG_LSB    2     // Register index at HADDR[5:2]
`define CNN_REG_W      4
`define CNN_IDX_LSB    6     // Element index at HADDR[13:6]

// Window stage plus four kernel stages
`define CNN_PIPE_LAT   5

`endif

// File: common/ahb_pkg.sv
`default_nettype none

// AHB-Lite bus encodings seen by the slave port
package ahb_pkg;

	// HTRANS
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_e;

	// HRESP, slave never errors
	typedef enum logic [1:0] {
		OKAY   = 2'b00
	} hresp_e;

endpackage

`default_nettype wire

// File: common/cnn_pkg.sv
`default_nettype none

`include "cnn_defines.svh"

// Register map and config word layouts
package cnn_pkg;

	// Word index at HADDR[5:2]
	typedef enum logic [`CNN_REG_W-1:0] {
		REG_DIMS       = 4'd0,
		REG_DELAYS     = 4'd1,
		REG_LAYER_CFG  = 4'd2,
		REG_PIXEL      = 4'd3,  // Indexed by pixel
		REG_WEIGHT     = 4'd4,  // Kernel * 9 + tap
		REG_SCALE_BIAS = 4'd5,  // Indexed by kernel
		REG_START      = 4'd6,
		REG_DONE       = 4'd7
	} reg_sel_e;

	typedef struct packed {
		logic [16-`CNN_DIM_W-1:0] rsvd_hi;
		logic [`CNN_DIM_W-1:0]    height;   // 20:16
		logic [16-`CNN_DIM_W-1:0] rsvd_lo;
		logic [`CNN_DIM_W-1:0]    width;    // 4:0
	} dims_t;

	typedef struct packed {
		logic [32-2*`CNN_DELAY_W-1:0] rsvd;
		logic [`CNN_DELAY_W-1:0]      hsync;     // 23:12
		logic [`CNN_DELAY_W-1:0]      start_up;  // 11:0
	} delays_t;

	typedef struct packed {
		logic [22:0] rsvd;
		logic [2:0]  act_shift;   // 8:6
		logic [4:0]  bias_shift;  // 5:1
		logic        act_type;    // 0 ReLU, 1 linear
	} layer_cfg_t;

	typedef struct packed {
		logic signed [`CNN_PARAM_W-1:0] bias;
		logic [`CNN_PARAM_W-1:0]        scale;
	} coef_t;

	// One bus word, decoded per selected register
	typedef union packed {
		logic [31:0] raw;
		dims_t       dims;
		delays_t     delays;
		layer_cfg_t  cfg;
		coef_t       coef;
	} reg_word_u;

endpackage

`default_nettype wire

// File: common/cnn_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defines.svh"

// Layer config and run control from the register block
interface cnn_cfg_if;
	logic [`CNN_DIM_W-1:0]   width;
	logic [`CNN_DIM_W-1:0]   height;
	logic [`CNN_DELAY_W-1:0] start_up;
	logic [`CNN_DELAY_W-1:0] hsync;
	logic                    act_type;
	logic [4:0]              bias_shift;
	logic [2:0]              act_shift;
	logic                    start;   // One-cycle run request
	logic                    done;    // One-cycle end of frame

	modport regs (output width, height, start_up, hsync, act_type, bias_shift,
		act_shift, start, input done);
	modport ctrl (input width, height, start_up, hsync, start, output done);
	modport kern (input act_type, bias_shift, act_shift);
endinterface

`default_nettype wire

// File: ahb_regs/cnn_ahb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defines.svh"

module cnn_ahb_regs
	import ahb_pkg::*;
	import cnn_pkg::*;
(
	input  logic                   HCLK,
	input  logic                   HRESETn,
	input  logic                   HSEL_i,
	input  logic                   HREADY_i,
	input  htrans_e                HTRANS_i,
	input  logic [31:0]            HADDR_i,
	input  logic                   HWRITE_i,
	input  logic [31:0]            HWDATA_i,
	output logic                   HREADYOUT_o,
	output hresp_e                 HRESP_o,
	output logic [31:0]            HRDATA_o,
	cnn_cfg_if.regs                cfg,
	// Memory write strobes, valid in the data phase
	output logic                   pix_we_o,
	output logic                   weight_we_o,
	output logic                   coef_we_o,
	output logic [`CNN_IMG_AW-1:0] mem_idx_o,
	output logic [31:0]            mem_data_o
);
	reg_sel_e               sel_q;   // Latched in address phase
	logic                   wr_q;
	logic [`CNN_IMG_AW-1:0] idx_q;
	logic                   addr_ok;
	logic                   wr_en;
	reg_word_u              wd;      // Write data view
	reg_word_u              rd;      // Readback view
	logic [`CNN_DIM_W-1:0]   width_q, height_q;
	logic [`CNN_DELAY_W-1:0] start_up_q, hsync_q;
	logic                    act_type_q;
	logic [4:0]              bias_shift_q;
	logic [2:0]              act_shift_q;
	logic                    start_q;
	logic                    done_flag_q;

	assign addr_ok = HSEL_i && HREADY_i && (HTRANS_i == NONSEQ || HTRANS_i == SEQ);
	assign wr_en   = wr_q;
	assign wd.raw  = HWDATA_i;

	// --------------------
	// Address phase
	// --------------------
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			sel_q <= REG_DIMS;
			wr_q  <= 1'b0;
			idx_q <= '0;
		end else if (addr_ok) begin
			sel_q <= reg_sel_e'(HADDR_i[`CNN_REG_LSB +: `CNN_REG_W]);
			wr_q  <= HWRITE_i;
			idx_q <= HADDR_i[`CNN_IDX_LSB +: `CNN_IMG_AW];
		end else begin
			wr_q  <= 1'b0;  // Idle or busy slot
		end
	end

	// --------------------
	// Data phase
	// --------------------
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			width_q      <= `CNN_DIM_W'(8);
			height_q     <= `CNN_DIM_W'(8);
			start_up_q   <= `CNN_DELAY_W'(16);
			hsync_q      <= `CNN_DELAY_W'(4);
			act_type_q   <= 1'b0;  // ReLU
			bias_shift_q <= 5'd9;
			act_shift_q  <= 3'd7;
			start_q      <= 1'b0;
			done_flag_q  <= 1'b0;
		end else begin
			start_q <= wr_en && sel_q == REG_START && wd.raw[0];
			if (wr_en) begin
				case (sel_q)
					REG_DIMS: begin
						width_q  <= wd.dims.width;
						height_q <= wd.dims.height;
					end
					REG_DELAYS: begin
						start_up_q <= wd.delays.start_up;
						hsync_q    <= wd.delays.hsync;
					end
					REG_LAYER_CFG: begin
						act_type_q   <= wd.cfg.act_type;
						bias_shift_q <= wd.cfg.bias_shift;
						act_shift_q  <= wd.cfg.act_shift;
					end
					default: ;
				endcase
			end
			// Frame end sets the flag, writing 1 clears it
			if (cfg.done)
				done_flag_q <= 1'b1;
			else if (wr_en && sel_q == REG_DONE && wd.raw[0])
				done_flag_q <= 1'b0;
		end
	end

	assign pix_we_o    = wr_en && sel_q == REG_PIXEL;
	assign weight_we_o = wr_en && sel_q == REG_WEIGHT;
	assign coef_we_o   = wr_en && sel_q == REG_SCALE_BIAS;
	assign mem_idx_o   = idx_q;
	assign mem_data_o  = HWDATA_i;

	// Readback, reserved bits stay 0
	always_comb begin
		rd = '0;
		case (sel_q)
			REG_DIMS: begin
				rd.dims.width  = width_q;
				rd.dims.height = height_q;
			end
			REG_DELAYS: begin
				rd.delays.start_up = start_up_q;
				rd.delays.hsync    = hsync_q;
			end
			REG_LAYER_CFG: begin
				rd.cfg.act_type   = act_type_q;
				rd.cfg.bias_shift = bias_shift_q;
				rd.cfg.act_shift  = act_shift_q;
			end
			REG_DONE: rd.raw[0] = done_flag_q;
			default: ;  // Indexed and start read 0
		endcase
	end

	assign HRDATA_o    = rd.raw;
	assign HREADYOUT_o = 1'b1;
	assign HRESP_o     = OKAY;

	assign cfg.width      = width_q;
	assign cfg.height     = height_q;
	assign cfg.start_up   = start_up_q;
	assign cfg.hsync      = hsync_q;
	assign cfg.act_type   = act_type_q;
	assign cfg.bias_shift = bias_shift_q;
	assign cfg.act_shift  = act_shift_q;
	assign cfg.start      = start_q;
endmodule

`default_nettype wire

// File: frame/cnn_frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defines.svh"

module cnn_frame_ctrl (
	input  logic                  HCLK,
	input  logic                  HRESETn,
	cnn_cfg_if.ctrl               cfg,
	output logic                  scan_o,   // One pixel per cycle in S_DATA
	output logic [`CNN_DIM_W-1:0] row_o,
	output logic [`CNN_DIM_W-1:0] col_o
);
	localparam int DRAIN_W = $clog2(`CNN_PIPE_LAT + 1);

	typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_HSYNC} state_e;

	state_e                  state_q;
	logic [`CNN_DELAY_W-1:0] dly_q;     // Remaining wait cycles minus one
	logic [`CNN_DIM_W-1:0]   row_q, col_q;
	logic [DRAIN_W-1:0]      drain_q;   // Pipeline flush after last pixel
	logic                    done_q;
	logic                    last_col, last_row;

	assign last_col = (col_q == cfg.width - 1'b1);
	assign last_row = (row_q == cfg.height - 1'b1);

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			state_q <= S_IDLE;
			dly_q   <= '0;
			row_q   <= '0;
			col_q   <= '0;
			drain_q <= '0;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (drain_q != '0) begin
				drain_q <= drain_q - 1'b1;
				done_q  <= (drain_q == DRAIN_W'(1));  // Last result already out
			end
			case (state_q)
				S_IDLE: begin
					if (cfg.start && drain_q == '0) begin
						row_q <= '0;
						col_q <= '0;
						if (cfg.start_up == '0) begin
							state_q <= S_DATA;
						end else begin
							state_q <= S_START;
							dly_q   <= cfg.start_up - 1'b1;
						end
					end
				end
				S_START, S_HSYNC: begin
					if (dly_q == '0)
						state_q <= S_DATA;
					else
						dly_q <= dly_q - 1'b1;
				end
				S_DATA: begin
					if (!last_col) begin
						col_q <= col_q + 1'b1;
					end else begin
						col_q <= '0;
						if (last_row) begin
							state_q <= S_IDLE;
							drain_q <= DRAIN_W'(`CNN_PIPE_LAT);
						end else begin
							row_q <= row_q + 1'b1;
							if (cfg.hsync != '0) begin  // Zero gap keeps scanning
								state_q <= S_HSYNC;
								dly_q   <= cfg.hsync - 1'b1;
							end
						end
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	assign scan_o   = (state_q == S_DATA);
	assign row_o    = row_q;
	assign col_o    = col_q;
	assign cfg.done = done_q;
endmodule

`default_nettype wire

// File: frame/cnn_window_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defines.svh"

module cnn_window_gen (
	input  logic                            HCLK,
	input  logic                            HRESETn,
	// Image load from the bus
	input  logic                            pix_we_i,
	input  logic [`CNN_IMG_AW-1:0]          mem_idx_i,
	input  logic [`CNN_PIX_W-1:0]           mem_data_i,
	// Scan position
	input  logic                            scan_i,
	input  logic [`CNN_DIM_W-1:0]           row_i,
	input  logic [`CNN_DIM_W-1:0]           col_i,
	input  logic [`CNN_DIM_W-1:0]           width_i,
	input  logic [`CNN_DIM_W-1:0]           height_i,
	output logic [`CNN_TAPS*`CNN_PIX_W-1:0] win_o,     // Tap 0 top-left in low byte
	output logic                            win_vld_o
);
	logic [`CNN_PIX_W-1:0]           img_mem [`CNN_IMG_DEPTH];
	logic [`CNN_DIM_W-1:0]           nb_row [3];
	logic [`CNN_DIM_W-1:0]           nb_col [3];
	logic [2:0]                      row_ok, col_ok;   // Neighbour inside image
	logic [`CNN_TAPS*`CNN_PIX_W-1:0] win_d;

	// Raster address, row * width + col
	function automatic logic [`CNN_IMG_AW-1:0] pix_addr(
		input logic [`CNN_DIM_W-1:0] r,
		input logic [`CNN_DIM_W-1:0] c,
		input logic [`CNN_DIM_W-1:0] w
	);
		logic [2*`CNN_DIM_W-1:0] lin;
		lin = r * w + c;
		return lin[`CNN_IMG_AW-1:0];
	endfunction

	always_ff @(posedge HCLK) begin
		if (pix_we_i)
			img_mem[mem_idx_i] <= mem_data_i;
	end

	// --------------------
	// Neighbourhood
	// --------------------
	assign nb_row[0] = row_i - 1'b1;
	assign nb_row[1] = row_i;
	assign nb_row[2] = row_i + 1'b1;
	assign nb_col[0] = col_i - 1'b1;
	assign nb_col[1] = col_i;
	assign nb_col[2] = col_i + 1'b1;

	assign row_ok = {row_i != height_i - 1'b1, 1'b1, row_i != '0};
	assign col_ok = {col_i != width_i - 1'b1, 1'b1, col_i != '0};

	always_comb begin
		win_d = '0;  // Zero padding outside the border
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				if (row_ok[r] && col_ok[c]) begin
					win_d[(r*3+c)*`CNN_PIX_W +: `CNN_PIX_W] =
						img_mem[pix_addr(nb_row[r], nb_col[c], width_i)];
				end
			end
		end
	end

	always_ff @(posedge HCLK) begin
		if (scan_i)
			win_o <= win_d;
	end

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn)
			win_vld_o <= 1'b0;
		else
			win_vld_o <= scan_i;  // Window lands one cycle after scan
	end
endmodule

`default_nettype wire

// File: conv/cnn_conv_kern.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defines.svh"

module cnn_conv_kern
	import cnn_pkg::*;
#(
	parameter int KERN_ID = 0
) (
	input  logic                            HCLK,
	input  logic                            HRESETn,
	cnn_cfg_if.kern                         cfg,
	input  logic                            weight_we_i,
	input  logic                            coef_we_i,
	input  logic [`CNN_IMG_AW-1:0]          mem_idx_i,
	input  logic [31:0]                     mem_data_i,
	input  logic [`CNN_TAPS*`CNN_PIX_W-1:0] win_i,
	input  logic                            win_vld_i,
	output logic [`CNN_PIX_W-1:0]           act_o,
	output logic                            act_vld_o
);
	localparam int PROD_W = 2*`CNN_PIX_W + 1;              // u8 * s8
	localparam int SUM_W  = PROD_W + $clog2(`CNN_TAPS);
	localparam int SCL_W  = SUM_W + `CNN_PARAM_W + 1;
	localparam int ACC_W  = SCL_W + 1;                      // Room for bias add

	logic signed [`CNN_PIX_W-1:0]   w_q [`CNN_TAPS];
	logic [`CNN_PARAM_W-1:0]        scale_q;
	logic signed [`CNN_PARAM_W-1:0] bias_q;
	coef_t                          coef_w;
	logic signed [PROD_W-1:0]       prod_q [`CNN_TAPS];
	logic signed [SUM_W-1:0]        sum_d, sum_q;
	logic signed [SCL_W-1:0]        mul_d, scl_q;
	logic signed [ACC_W-1:0]        biased, relu_v, shifted;
	logic [`CNN_PIX_W-1:0]          act_d;
	logic [3:0]                     vld_q;    // One bit per stage

	assign coef_w = mem_data_i;

	// --------------------
	// Coefficient store
	// --------------------
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			for (int t = 0; t < `CNN_TAPS; t++)
				w_q[t] <= '0;
			scale_q <= '0;
			bias_q  <= '0;
		end else begin
			if (weight_we_i && mem_idx_i / `CNN_TAPS == KERN_ID)
				w_q[mem_idx_i % `CNN_TAPS] <= mem_data_i[`CNN_PIX_W-1:0];
			if (coef_we_i && mem_idx_i == KERN_ID) begin
				scale_q <= coef_w.scale;
				bias_q  <= coef_w.bias;
			end
		end
	end

	// --------------------
	// Arithmetic pipeline
	// --------------------
	always_comb begin
		sum_d = '0;
		for (int t = 0; t < `CNN_TAPS; t++)
			sum_d = sum_d + prod_q[t];
	end

	assign mul_d   = sum_q * $signed({1'b0, scale_q});
	assign biased  = scl_q + bias_q;
	assign relu_v  = (!cfg.act_type && biased < 0) ? '0 : biased;
	assign shifted = relu_v >>> cfg.act_shift;

	// Clamp to u8 for ReLU or s8 for linear
	always_comb begin
		if (!cfg.act_type)
			act_d = (shifted > 255) ? 8'hff : shifted[`CNN_PIX_W-1:0];
		else if (shifted > 127)
			act_d = 8'h7f;
		else if (shifted < -128)
			act_d = 8'h80;
		else
			act_d = shifted[`CNN_PIX_W-1:0];
	end

	always_ff @(posedge HCLK) begin
		for (int t = 0; t < `CNN_TAPS; t++)  // Stage 1 products
			prod_q[t] <= $signed({1'b0, win_i[t*`CNN_PIX_W +: `CNN_PIX_W]}) * w_q[t];
		sum_q <= sum_d;                       // Stage 2
		scl_q <= mul_d >>> cfg.bias_shift;    // Stage 3
		act_o <= act_d;                       // Stage 4
	end

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn)
			vld_q <= '0;
		else
			vld_q <= {vld_q[2:0], win_vld_i};
	end

	assign act_vld_o = vld_q[3];
endmodule

`default_nettype wire

// File: src/cnn_accel_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defines.svh"

module cnn_accel_top
	import ahb_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	// AHB slave
	input  logic        HSEL_i,
	input  logic        HREADY_i,
	input  htrans_e     HTRANS_i,
	input  logic [31:0] HADDR_i,
	input  logic        HWRITE_i,
	input  logic [31:0] HWDATA_i,
	output logic        HREADYOUT_o,
	output hresp_e      HRESP_o,
	output logic [31:0] HRDATA_o,
	// Four activations per pixel
	output logic [31:0] out_pixel_o,
	output logic        out_valid_o
);
	cnn_cfg_if u_cfg ();

	logic                              pix_we;
	logic                              weight_we;
	logic                              coef_we;
	logic [`CNN_IMG_AW-1:0]            mem_idx;
	logic [31:0]                       mem_data;
	logic                              scan;
	logic [`CNN_DIM_W-1:0]             row;
	logic [`CNN_DIM_W-1:0]             col;
	logic [`CNN_TAPS*`CNN_PIX_W-1:0]   win;
	logic                              win_vld;
	logic [`CNN_PIX_W-1:0]             act [`CNN_N_KERN];
	logic [`CNN_N_KERN-1:0]            act_vld;

	cnn_ahb_regs u_regs (
		.HCLK, .HRESETn,
		.HSEL_i, .HREADY_i, .HTRANS_i, .HADDR_i, .HWRITE_i, .HWDATA_i,
		.HREADYOUT_o, .HRESP_o, .HRDATA_o,
		.cfg (u_cfg),
		.pix_we_o (pix_we), .weight_we_o (weight_we), .coef_we_o (coef_we),
		.mem_idx_o (mem_idx), .mem_data_o (mem_data)
	);

	cnn_frame_ctrl u_ctrl (
		.HCLK, .HRESETn, .cfg (u_cfg),
		.scan_o (scan), .row_o (row), .col_o (col)
	);

	cnn_window_gen u_win (
		.HCLK, .HRESETn,
		.pix_we_i (pix_we), .mem_idx_i (mem_idx), .mem_data_i (mem_data[`CNN_PIX_W-1:0]),
		.scan_i (scan), .row_i (row), .col_i (col),
		.width_i (u_cfg.width), .height_i (u_cfg.height),
		.win_o (win), .win_vld_o (win_vld)
	);

	// --------------------
	// Output channels, channel 0 in the low byte
	// --------------------
	for (genvar k = 0; k < `CNN_N_KERN; k++) begin : g_kern
		cnn_conv_kern #(.KERN_ID (k)) u_kern (
			.HCLK, .HRESETn, .cfg (u_cfg),
			.weight_we_i (weight_we), .coef_we_i (coef_we),
			.mem_idx_i (mem_idx), .mem_data_i (mem_data),
			.win_i (win), .win_vld_i (win_vld),
			.act_o (act[k]), .act_vld_o (act_vld[k])
		);
		assign out_pixel_o[k*`CNN_PIX_W +: `CNN_PIX_W] = act[k];
	end

	assign out_valid_o = &act_vld;  // Channels run in lockstep
endmodule

`default_nettype wire

// File: verification/tb_cnn_model.svh
`ifndef TB_CNN_MODEL_SVH
`define TB_CNN_MODEL_SVH

// --------------------
// Shadow of what the host wrote
// --------------------
logic [7:0]         img_ref [`CNN_IMG_DEPTH];
logic signed [7:0]  wgt_ref [`CNN_N_KERN][`CNN_TAPS];
logic [15:0]        scale_ref [`CNN_N_KERN];
logic signed [15:0] bias_ref [`CNN_N_KERN];
int                 img_w;
int                 img_h;
logic               act_type_ref;     // 0 ReLU, 1 linear
logic [4:0]         bias_shift_ref;
logic [2:0]         act_shift_ref;

// Register words as the map lays them out
function automatic logic [31:0] dims_word(input logic [4:0] w, input logic [4:0] h);
	return {11'h0, h, 11'h0, w};
endfunction

function automatic logic [31:0] delays_word(input logic [11:0] su, input logic [11:0] hs);
	return {8'h0, hs, su};
endfunction

function automatic logic [31:0] layer_word(input logic at, input logic [4:0] bsh,
	input logic [2:0] ash);
	return {23'h0, ash, bsh, at};
endfunction

// Pixel at (rr, cc), zero outside the image
function automatic int tap_value(input int rr, input int cc);
	if (rr < 0 || rr >= img_h || cc < 0 || cc >= img_w)
		return 0;
	return int'(img_ref[rr * img_w + cc]);
endfunction

// One channel: MAC, scale, bias, activation, clamp
function automatic logic [7:0] channel_act(input int k, input int r, input int c);
	longint acc;
	int     t;
	acc = 0;
	t   = 0;
	for (int dr = -1; dr <= 1; dr++) begin
		for (int dc = -1; dc <= 1; dc++) begin
			acc += longint'(tap_value(r + dr, c + dc)) * longint'(wgt_ref[k][t]);
			t++;  // Row-major tap order
		end
	end
	acc = acc * longint'(scale_ref[k]);
	acc = acc >>> bias_shift_ref;
	acc = acc + longint'(bias_ref[k]);
	if (!act_type_ref && acc < 0)
		acc = 0;  // ReLU
	acc = acc >>> act_shift_ref;
	if (!act_type_ref) begin
		if (acc > 255)
			acc = 255;
	end else if (acc > 127) begin
		acc = 127;
	end else if (acc < -128) begin
		acc = -128;  // Two's complement 8'h80
	end
	return acc[7:0];
endfunction

// Four channels, channel 0 in the low byte
function automatic logic [31:0] expected_word(input int r, input int c);
	logic [31:0] word;
	for (int k = 0; k < `CNN_N_KERN; k++)
		word[k*8 +: 8] = channel_act(k, r, c);
	return word;
endfunction

`endif

// File: verification/tb_cnn_accel.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defines.svh"

module tb_cnn_accel
	import ahb_pkg::*;
	import cnn_pkg::*;
();
	logic        HCLK;
	logic        HRESETn;
	logic        HSEL;
	logic        HREADY;
	htrans_e     HTRANS;
	logic [31:0] HADDR;
	logic        HWRITE;
	logic [31:0] HWDATA;
	logic        HREADYOUT;
	hresp_e      HRESP;
	logic [31:0] HRDATA;
	logic [31:0] out_pixel;
	logic        out_valid;

	logic [31:0] rng_state;
	logic [31:0] out_q [$];   // Words seen on out_pixel_o
	int          n_checks;
	int          n_errors;

	cnn_accel_top dut_i (
		.HCLK, .HRESETn,
		.HSEL_i (HSEL), .HREADY_i (HREADY), .HTRANS_i (HTRANS), .HADDR_i (HADDR),
		.HWRITE_i (HWRITE), .HWDATA_i (HWDATA),
		.HREADYOUT_o (HREADYOUT), .HRESP_o (HRESP), .HRDATA_o (HRDATA),
		.out_pixel_o (out_pixel), .out_valid_o (out_valid)
	);

	always #4 HCLK = ~HCLK;  // 8 ns period

	`include "tb_cnn_model.svh"

	// Upper half of the LCG state, low bits cycle too fast
	function automatic logic [15:0] next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state[31:16];
	endfunction

	// --------------------
	// AHB transfers, entered 1 ns after a rising edge
	// --------------------
	task automatic bus_write(input logic [3:0] sel, input int idx, input logic [31:0] data);
		HSEL   = 1'b1;
		HTRANS = NONSEQ;
		HADDR  = {18'h0, idx[7:0], sel, 2'b00};
		HWRITE = 1'b1;
		@(posedge HCLK);
		#1;
		HSEL   = 1'b0;  // Data phase
		HTRANS = IDLE;
		HWRITE = 1'b0;
		HWDATA = data;
		@(posedge HCLK);
		#1;
	endtask

	task automatic bus_read(input logic [3:0] sel, output logic [31:0] data);
		HSEL   = 1'b1;
		HTRANS = NONSEQ;
		HADDR  = {26'h0, sel, 2'b00};
		HWRITE = 1'b0;
		@(posedge HCLK);
		#1;
		HSEL   = 1'b0;
		HTRANS = IDLE;
		data   = HRDATA;  // Valid through the data phase
		n_checks++;
		if (HREADYOUT !== 1'b1 || HRESP !== OKAY) begin
			n_errors++;
			$display("error HRESP_o: expected %h, got %h (HREADYOUT_o %h)", OKAY, HRESP, HREADYOUT);
		end
		@(posedge HCLK);
		#1;
	endtask

	task automatic check_reg(input logic [3:0] sel, input logic [31:0] exp, input string what);
		logic [31:0] data;
		bus_read(sel, data);
		n_checks++;
		if (data !== exp) begin
			n_errors++;
			$display("error HRDATA_o %s: expected %h, got %h", what, exp, data);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (n_errors == errs_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, n_errors - errs_before);
	endtask

	// Config, image, weights and coefficients, mirrored into the model
	task automatic load_layer(input logic [4:0] w, input logic [4:0] h, input logic at,
		input logic [4:0] bsh, input logic [2:0] ash, input logic [11:0] su,
		input logic [11:0] hs);
		logic [15:0] r;
		img_w          = int'(w);
		img_h          = int'(h);
		act_type_ref   = at;
		bias_shift_ref = bsh;
		act_shift_ref  = ash;
		bus_write(REG_DIMS, 0, dims_word(w, h));
		bus_write(REG_DELAYS, 0, delays_word(su, hs));
		bus_write(REG_LAYER_CFG, 0, layer_word(at, bsh, ash));
		for (int i = 0; i < img_w * img_h; i++) begin
			r = next_rand();
			img_ref[i] = r[7:0];
			bus_write(REG_PIXEL, i, {24'h0, r[7:0]});
		end
		for (int k = 0; k < `CNN_N_KERN; k++) begin
			for (int t = 0; t < `CNN_TAPS; t++) begin
				r = next_rand();
				wgt_ref[k][t] = r[7:0];
				bus_write(REG_WEIGHT, k * `CNN_TAPS + t, {24'h0, r[7:0]});
			end
			r = next_rand();
			if (k == `CNN_N_KERN - 1)
				scale_ref[k] = {1'b1, r[14:0]};  // Top bit set, scale is unsigned
			else
				scale_ref[k] = {6'h0, r[9:0]};   // Keeps most results off the rails
			r = next_rand();
			bias_ref[k] = {{4{r[11]}}, r[11:0]};  // Around +-2048
			bus_write(REG_SCALE_BIAS, k, {bias_ref[k], scale_ref[k]});
		end
	endtask

	// Start one frame, wait for done, compare every word in raster order
	task automatic run_frame(input int n);
		logic [31:0] data;
		logic [31:0] exp;
		int          polls;
		n_checks++;
		if (out_q.size() != 0) begin
			n_errors++;
			$display("out_valid_o pulsed %0d times while idle", out_q.size());
		end
		bus_write(REG_DONE, 0, 32'h1);  // Clear flag of any earlier frame
		bus_write(REG_START, 0, 32'h1);
		polls = 0;
		data  = '0;
		while (data[0] !== 1'b1 && polls < 500) begin
			bus_read(REG_DONE, data);
			polls++;
		end
		n_checks++;
		if (data[0] !== 1'b1) begin
			n_errors++;
			$display("timeout, done flag never set after start");
		end
		repeat (20) @(posedge HCLK);  // Room for stray words
		#1;
		n_checks++;
		if (out_q.size() != n) begin
			n_errors++;
			$display("error out_valid_o count: expected %h, got %h", n, out_q.size());
		end
		for (int i = 0; i < n && i < out_q.size(); i++) begin
			exp = expected_word(i / img_w, i % img_w);
			n_checks++;
			if (out_q[i] !== exp) begin
				n_errors++;
				$display("error out_pixel_o word %0d: expected %h, got %h", i, exp, out_q[i]);
			end
		end
		out_q.delete();
	endtask

	// Monitor, sampled away from the rising edge
	always @(negedge HCLK) begin
		if (HRESETn && out_valid)
			out_q.push_back(out_pixel);
	end

	initial begin
		int          errs;
		logic [31:0] raw;
		logic [4:0]  w;
		logic [4:0]  h;
		rng_state = 32'd90;
		n_checks  = 0;
		n_errors  = 0;
		HCLK      = 1'b0;
		HRESETn   = 1'b0;
		HSEL      = 1'b0;
		HREADY    = 1'b1;
		HTRANS    = IDLE;
		HADDR     = '0;
		HWRITE    = 1'b0;
		HWDATA    = '0;
		repeat (5) @(posedge HCLK);
		#1;
		HRESETn = 1'b1;
		@(posedge HCLK);
		#1;

		// --------------------
		// Register map
		// --------------------
		errs = n_errors;
		check_reg(REG_DIMS, dims_word(5'd8, 5'd8), "REG_DIMS");
		check_reg(REG_DELAYS, delays_word(12'd16, 12'd4), "REG_DELAYS");
		check_reg(REG_LAYER_CFG, layer_word(1'b0, 5'd9, 3'd7), "REG_LAYER_CFG");
		check_reg(REG_DONE, 32'h0, "REG_DONE");
		report_test("test 1 reset defaults", errs);

		errs = n_errors;
		repeat (6) begin
			raw = {next_rand(), next_rand()};  // Reserved bits random too
			w = {1'b0, raw[3:0]} + 5'd1;
			h = {1'b0, raw[19:16]} + 5'd1;
			raw[4:0]   = w;
			raw[20:16] = h;
			bus_write(REG_DIMS, 0, raw);
			check_reg(REG_DIMS, dims_word(w, h), "REG_DIMS");
			raw = {next_rand(), next_rand()};
			bus_write(REG_DELAYS, 0, raw);
			check_reg(REG_DELAYS, delays_word(raw[11:0], raw[23:12]), "REG_DELAYS");
			raw = {next_rand(), next_rand()};
			bus_write(REG_LAYER_CFG, 0, raw);
			check_reg(REG_LAYER_CFG, layer_word(raw[0], raw[5:1], raw[8:6]), "REG_LAYER_CFG");
		end
		report_test("test 2 register readback", errs);

		// --------------------
		// Frames
		// --------------------
		errs = n_errors;
		raw  = {16'h0, next_rand()};
		load_layer(5'd8, 5'd6, 1'b0, 5'd11 + {3'h0, raw[1:0]}, 3'd3 + {1'b0, raw[3:2]},
			12'd2 + {9'h0, raw[6:4]}, {10'h0, raw[9:8]});
		run_frame(48);
		report_test("test 3 relu 8x6 frame", errs);

		errs = n_errors;
		raw  = {16'h0, next_rand()};
		load_layer(5'd5, 5'd7, 1'b1, 5'd13 + {3'h0, raw[1:0]}, 3'd4 + {1'b0, raw[3:2]},
			{10'h0, raw[5:4]}, 12'd1 + {9'h0, raw[8:6]});
		run_frame(35);
		report_test("test 4 linear 5x7 frame", errs);

		errs = n_errors;
		check_reg(REG_DONE, 32'h1, "REG_DONE after frame");
		bus_write(REG_DONE, 0, 32'h1);
		check_reg(REG_DONE, 32'h0, "REG_DONE after clear");
		repeat (30) @(posedge HCLK);
		#1;
		n_checks++;
		if (out_q.size() != 0) begin
			n_errors++;
			$display("out_valid_o pulsed %0d times while idle", out_q.size());
		end
		report_test("test 5 done flag and idle", errs);

		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end
endmodule

`default_nettype wire

// File: flist.f
+incdir+common
+incdir+verification
common/ahb_pkg.sv
common/cnn_pkg.sv
common/cnn_cfg_if.sv
ahb_regs/cnn_ahb_regs.sv
frame/cnn_frame_ctrl.sv
frame/cnn_window_gen.sv
conv/cnn_conv_kern.sv
src/cnn_accel_top.sv
verification/tb_cnn_accel.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and decide on the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal --top-module tb_cnn_accel -f flist.f &&
./obj_dir/Vtb_cnn_accel | tee /dev/stderr | grep -x "TB PASSED" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
